//--- rtl/axiPkg.sv
/*
 * AXI protocol widths and encodings shared by the write and read engines.
 * Import inside a module body, or use scoped names in port lists.
 */
package axiPkg;

  //--------------------------------------------------------------------
  // channel field widths
  //--------------------------------------------------------------------
  localparam int LenWidth  = 8;  // AxLEN, bursts up to 256 beats
  localparam int SizeWidth = 3;  // AxSIZE
  localparam int RespWidth = 2;  // BRESP / RRESP

  // response codes, EXOKAY and DECERR never issued
  typedef enum logic [RespWidth-1:0] {
    RespOkay   = 2'b00,
    RespSlvErr = 2'b10
  } respE;

  // beat size opcode, bytes per beat
  typedef enum logic [SizeWidth-1:0] {
    Size1   = 3'd0,
    Size2   = 3'd1,
    Size4   = 3'd2,
    Size8   = 3'd3,
    Size16  = 3'd4,
    Size32  = 3'd5,
    Size64  = 3'd6,
    Size128 = 3'd7
  } sizeE;

  // address step per beat for an incrementing burst
  function automatic logic [15:0] beatBytes(sizeE size);
    return 16'd1 << size;
  endfunction

endpackage

//--- rtl/engPkg.sv
/*
 * State encodings of the AXI write and read engines.
 * Also used by the protocol checks bound into the top level.
 */
package engPkg;

  //--------------------------------------------------------------------
  // write engine
  //--------------------------------------------------------------------
  typedef enum logic [1:0] {
    WrIdle = 2'd0,  // waiting for an AW command
    WrData = 2'd1,  // accepting W beats
    WrResp = 2'd2   // holding B until BREADY
  } wrStateE;

  //--------------------------------------------------------------------
  // read engine
  //--------------------------------------------------------------------
  typedef enum logic {
    RdIdle = 1'b0,  // waiting for an AR command
    RdData = 1'b1   // presenting R beats
  } rdStateE;

endpackage

//--- rtl/addrCmdIf.sv
/*
 * One queued address command, passed from an address queue to an engine.
 * Transfers on a cycle with valid and ready both high.
 */
interface addrCmdIf #(
  parameter int IdWidth   = 4,
  parameter int AddrWidth = 32
);
  import axiPkg::*;

  logic [IdWidth-1:0]   id;
  logic [AddrWidth-1:0] addr;
  logic [LenWidth-1:0]  len;   // beats minus one
  sizeE                 size;
  logic                 valid;
  logic                 ready;

  // queue side
  modport source (output id, addr, len, size, valid, input ready);
  // engine side
  modport sink   (input id, addr, len, size, valid, output ready);

endinterface

//--- rtl/memWrIf.sv
/*
 * Byte-enabled write port of the word memory, driven by the write engine.
 */
interface memWrIf #(
  parameter int AddrWidth = 32,
  parameter int DataWidth = 32
);
  logic                   en;
  logic [AddrWidth-1:0]   wordAddr;  // word index, not byte address
  logic [DataWidth-1:0]   data;
  logic [DataWidth/8-1:0] strb;

  modport master (output en, wordAddr, data, strb);
  modport slave  (input en, wordAddr, data, strb);

endinterface

//--- rtl/axiAddrQueue.sv
/*
 * Small circular FIFO in front of an engine. Accepts an AXI address
 * channel (AW or AR) and presents the oldest command on cmd.
 */
module axiAddrQueue #(
  parameter int IdWidth    = 4,
  parameter int AddrWidth  = 32,
  parameter int QueueDepth = 4
) (
  input  logic                         ACLK,
  input  logic                         ARESETn,
  input  logic [IdWidth-1:0]           id,
  input  logic [AddrWidth-1:0]         addr,
  input  logic [axiPkg::LenWidth-1:0]  len,
  input  logic [axiPkg::SizeWidth-1:0] size,
  input  logic                         valid,
  output logic                         ready,
  addrCmdIf.source                     cmd
);
  import axiPkg::*;

  localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int CntWidth = $clog2(QueueDepth + 1);

  logic [IdWidth-1:0]   idMem   [QueueDepth];
  logic [AddrWidth-1:0] addrMem [QueueDepth];
  logic [LenWidth-1:0]  lenMem  [QueueDepth];
  sizeE                 sizeMem [QueueDepth];

  logic [PtrWidth-1:0] wrPtr, rdPtr;
  logic [CntWidth-1:0] count;
  logic                push, pop;

  assign ready = (count != CntWidth'(QueueDepth));  // room left
  assign push  = valid & ready;
  assign pop   = cmd.valid & cmd.ready;

  assign cmd.valid = (count != '0);
  assign cmd.id    = idMem[rdPtr];
  assign cmd.addr  = addrMem[rdPtr];
  assign cmd.len   = lenMem[rdPtr];
  assign cmd.size  = sizeMem[rdPtr];

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= (wrPtr == PtrWidth'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)  rdPtr <= (rdPtr == PtrWidth'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // both or neither
      endcase
    end
  end

  // payload storage
  always_ff @(posedge ACLK) begin
    if (push) begin
      idMem[wrPtr]   <= id;
      addrMem[wrPtr] <= addr;
      lenMem[wrPtr]  <= len;
      sizeMem[wrPtr] <= sizeE'(size);
    end
  end

endmodule

//--- rtl/axiWriteEngine.sv
/*
 * Write burst sequencer. Pops an AW command, accepts len+1 W beats into
 * the memory write port and returns B with the echoed ID. A WLAST that
 * disagrees with the beat count turns BRESP into SLVERR.
 */
module axiWriteEngine #(
  parameter int   IdWidth   = 4,
  parameter int   AddrWidth = 32,
  parameter int   DataWidth = 32,
  localparam int  StrbWidth = DataWidth / 8
) (
  input  logic                         ACLK,
  input  logic                         ARESETn,
  addrCmdIf.sink                       cmd,
  input  logic [DataWidth-1:0]         WDATA,
  input  logic [StrbWidth-1:0]         WSTRB,
  input  logic                         WLAST,
  input  logic                         WVALID,
  output logic                         WREADY,
  output logic [IdWidth-1:0]           BID,
  output logic [axiPkg::RespWidth-1:0] BRESP,
  output logic                         BVALID,
  input  logic                         BREADY,
  memWrIf.master                       mem
);
  import axiPkg::*;
  import engPkg::*;

  localparam int StrbShift = $clog2(StrbWidth);

  wrStateE              state;
  logic [IdWidth-1:0]   idReg;
  logic [AddrWidth-1:0] addrReg;    // byte address of the next beat
  sizeE                 sizeReg;
  logic [LenWidth-1:0]  beatsLeft;  // beats after the current one
  logic                 wlastErr;   // sticky over the burst
  logic                 pop, beat, lastBeat;

  assign cmd.ready = (state == WrIdle);
  assign pop       = cmd.valid & cmd.ready;
  assign WREADY    = (state == WrData);
  assign beat      = WVALID & WREADY;
  assign lastBeat  = (beatsLeft == '0);

  assign BVALID = (state == WrResp);
  assign BID    = idReg;
  assign BRESP  = wlastErr ? RespSlvErr : RespOkay;

  //--------------------------------------------------------------------
  // memory write port, one word per accepted beat
  //--------------------------------------------------------------------
  assign mem.en       = beat;
  assign mem.wordAddr = addrReg >> StrbShift;
  assign mem.data     = WDATA;
  assign mem.strb     = WSTRB;

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state     <= WrIdle;
      beatsLeft <= '0;
      wlastErr  <= 1'b0;
    end else begin
      case (state)
        WrIdle: if (pop) begin
          beatsLeft <= cmd.len;
          wlastErr  <= 1'b0;
          state     <= WrData;
        end
        WrData: if (beat) begin
          if (WLAST != lastBeat) wlastErr <= 1'b1;  // early or missing
          beatsLeft <= beatsLeft - 1'b1;
          if (lastBeat) state <= WrResp;
        end
        WrResp: if (BREADY) state <= WrIdle;
        default: state <= WrIdle;
      endcase
    end
  end

  // command payload and address stepping
  always_ff @(posedge ACLK) begin
    if (pop) begin
      idReg   <= cmd.id;
      addrReg <= cmd.addr;
      sizeReg <= cmd.size;
    end else if (beat) begin
      addrReg <= addrReg + AddrWidth'(beatBytes(sizeReg));
    end
  end

endmodule

//--- rtl/axiReadEngine.sv
/*
 * Read burst sequencer. Pops an AR command and streams len+1 words from
 * the memory on R. The next word is registered on every R handshake.
 */
module axiReadEngine #(
  parameter int IdWidth   = 4,
  parameter int AddrWidth = 32,
  parameter int DataWidth = 32
) (
  input  logic                         ACLK,
  input  logic                         ARESETn,
  addrCmdIf.sink                       cmd,
  output logic [AddrWidth-1:0]         rdAddr,
  input  logic [DataWidth-1:0]         rdData,
  output logic [IdWidth-1:0]           RID,
  output logic [DataWidth-1:0]         RDATA,
  output logic [axiPkg::RespWidth-1:0] RRESP,
  output logic                         RLAST,
  output logic                         RVALID,
  input  logic                         RREADY
);
  import axiPkg::*;
  import engPkg::*;

  localparam int StrbShift = $clog2(DataWidth / 8);

  rdStateE              state;
  logic [AddrWidth-1:0] addrReg;    // address of the word loaded next
  sizeE                 sizeReg;
  logic [LenWidth-1:0]  beatsLeft;  // beats still to load
  logic                 pop, hs;

  assign cmd.ready = (state == RdIdle);
  assign pop       = cmd.valid & cmd.ready;
  assign hs        = RVALID & RREADY;
  assign RVALID    = (state == RdData);
  assign RRESP     = RespOkay;

  // first word comes straight from the command address
  assign rdAddr = ((state == RdIdle) ? cmd.addr : addrReg) >> StrbShift;

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state     <= RdIdle;
      RLAST     <= 1'b0;
      beatsLeft <= '0;
    end else begin
      case (state)
        RdIdle: if (pop) begin
          beatsLeft <= cmd.len;
          RLAST     <= (cmd.len == '0);  // single-beat burst
          state     <= RdData;
        end
        RdData: if (hs) begin
          if (RLAST) begin
            RLAST <= 1'b0;
            state <= RdIdle;
          end else begin
            beatsLeft <= beatsLeft - 1'b1;
            RLAST     <= (beatsLeft == LenWidth'(1));
          end
        end
        default: state <= RdIdle;
      endcase
    end
  end

  //--------------------------------------------------------------------
  // beat payload, loaded at start and on each non-final handshake
  //--------------------------------------------------------------------
  always_ff @(posedge ACLK) begin
    if (pop) begin
      RID     <= cmd.id;
      RDATA   <= rdData;
      sizeReg <= cmd.size;
      addrReg <= cmd.addr + AddrWidth'(beatBytes(cmd.size));
    end else if (hs && !RLAST) begin
      RDATA   <= rdData;
      addrReg <= addrReg + AddrWidth'(beatBytes(sizeReg));
    end
  end

endmodule

//--- rtl/axiMemArray.sv
/*
 * Word memory behind the AXI slave. Writes merge strobed bytes, reads
 * are combinational. Word k holds k after configuration.
 */
module axiMemArray #(
  parameter int AddrWidth = 32,
  parameter int DataWidth = 32,
  parameter int MemBytes  = 1024
) (
  input  logic                 ACLK,
  memWrIf.slave                wr,
  input  logic [AddrWidth-1:0] rdAddr,  // word index
  output logic [DataWidth-1:0] rdData
);

  localparam int StrbWidth = DataWidth / 8;
  localparam int Words     = MemBytes / StrbWidth;
  localparam int IdxWidth  = $clog2(Words);

  logic [DataWidth-1:0] mem [Words];
  logic [IdxWidth-1:0]  wrIdx, rdIdx;

  // index wraps modulo the word count
  assign wrIdx = wr.wordAddr[IdxWidth-1:0];
  assign rdIdx = rdAddr[IdxWidth-1:0];

  initial begin
    for (int k = 0; k < Words; k++) begin
      mem[k] = DataWidth'(k);
    end
  end

  always_ff @(posedge ACLK) begin
    if (wr.en) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (wr.strb[b]) mem[wrIdx][8*b +: 8] <= wr.data[8*b +: 8];
      end
    end
  end

  assign rdData = mem[rdIdx];

endmodule

//--- rtl/axiMemTop.sv
/*
 * AXI memory slave top level. Plain AXI ports; the AW and AR queues feed
 * the write and read engines, which share one word memory.
 */
module axiMemTop #(
  parameter int IdWidth    = 4,
  parameter int AddrWidth  = 32,
  parameter int DataWidth  = 32,
  parameter int MemBytes   = 1024,
  parameter int QueueDepth = 4
) (
  input  logic                         ACLK,
  input  logic                         ARESETn,
  // write address
  input  logic [IdWidth-1:0]           AWID,
  input  logic [AddrWidth-1:0]         AWADDR,
  input  logic [axiPkg::LenWidth-1:0]  AWLEN,
  input  logic [axiPkg::SizeWidth-1:0] AWSIZE,
  input  logic                         AWVALID,
  output logic                         AWREADY,
  // write data
  input  logic [DataWidth-1:0]         WDATA,
  input  logic [DataWidth/8-1:0]       WSTRB,
  input  logic                         WLAST,
  input  logic                         WVALID,
  output logic                         WREADY,
  // write response
  output logic [IdWidth-1:0]           BID,
  output logic [axiPkg::RespWidth-1:0] BRESP,
  output logic                         BVALID,
  input  logic                         BREADY,
  // read address
  input  logic [IdWidth-1:0]           ARID,
  input  logic [AddrWidth-1:0]         ARADDR,
  input  logic [axiPkg::LenWidth-1:0]  ARLEN,
  input  logic [axiPkg::SizeWidth-1:0] ARSIZE,
  input  logic                         ARVALID,
  output logic                         ARREADY,
  // read data
  output logic [IdWidth-1:0]           RID,
  output logic [DataWidth-1:0]         RDATA,
  output logic [axiPkg::RespWidth-1:0] RRESP,
  output logic                         RLAST,
  output logic                         RVALID,
  input  logic                         RREADY
);

  addrCmdIf #(.IdWidth(IdWidth), .AddrWidth(AddrWidth)) awCmd ();
  addrCmdIf #(.IdWidth(IdWidth), .AddrWidth(AddrWidth)) arCmd ();
  memWrIf #(.AddrWidth(AddrWidth), .DataWidth(DataWidth)) memWr ();

  logic [AddrWidth-1:0] rdAddr;
  logic [DataWidth-1:0] rdData;

  //--------------------------------------------------------------------
  // address queues
  //--------------------------------------------------------------------
  axiAddrQueue #(.IdWidth(IdWidth), .AddrWidth(AddrWidth), .QueueDepth(QueueDepth)) awQueue (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .id(AWID), .addr(AWADDR), .len(AWLEN), .size(AWSIZE),
    .valid(AWVALID), .ready(AWREADY),
    .cmd(awCmd.source)
  );

  axiAddrQueue #(.IdWidth(IdWidth), .AddrWidth(AddrWidth), .QueueDepth(QueueDepth)) arQueue (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .id(ARID), .addr(ARADDR), .len(ARLEN), .size(ARSIZE),
    .valid(ARVALID), .ready(ARREADY),
    .cmd(arCmd.source)
  );

  //--------------------------------------------------------------------
  // engines and memory
  //--------------------------------------------------------------------
  axiWriteEngine #(.IdWidth(IdWidth), .AddrWidth(AddrWidth), .DataWidth(DataWidth)) wrEngine (
    .ACLK(ACLK), .ARESETn(ARESETn), .cmd(awCmd.sink),
    .WDATA(WDATA), .WSTRB(WSTRB), .WLAST(WLAST), .WVALID(WVALID), .WREADY(WREADY),
    .BID(BID), .BRESP(BRESP), .BVALID(BVALID), .BREADY(BREADY),
    .mem(memWr.master)
  );

  axiReadEngine #(.IdWidth(IdWidth), .AddrWidth(AddrWidth), .DataWidth(DataWidth)) rdEngine (
    .ACLK(ACLK), .ARESETn(ARESETn), .cmd(arCmd.sink),
    .rdAddr(rdAddr), .rdData(rdData),
    .RID(RID), .RDATA(RDATA), .RRESP(RRESP), .RLAST(RLAST),
    .RVALID(RVALID), .RREADY(RREADY)
  );

  axiMemArray #(.AddrWidth(AddrWidth), .DataWidth(DataWidth), .MemBytes(MemBytes)) memArray (
    .ACLK(ACLK), .wr(memWr.slave), .rdAddr(rdAddr), .rdData(rdData)
  );

endmodule

//--- dv/axiMem_asserts.sv
/*
 * AXI handshake checks for the memory slave, bound into the top level.
 */
module axiMemAsserts #(
  parameter int IdWidth   = 4,
  parameter int DataWidth = 32
) (
  input logic                         ACLK,
  input logic                         ARESETn,
  input logic                         WREADY,
  input logic [IdWidth-1:0]           BID,
  input logic [axiPkg::RespWidth-1:0] BRESP,
  input logic                         BVALID,
  input logic                         BREADY,
  input logic [DataWidth-1:0]         RDATA,
  input logic                         RLAST,
  input logic                         RVALID,
  input logic                         RREADY
);
  timeunit 1ns;
  timeprecision 100ps;

  int fails = 0;

  // B stays up with a stable payload until taken
  bHold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    BVALID && !BREADY |=> BVALID && $stable(BID) && $stable(BRESP))
    else begin
      fails++;
      $error("B channel changed before BREADY");
    end

  rHold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    RVALID && !RREADY |=> RVALID && $stable(RDATA) && $stable(RLAST))
    else begin
      fails++;
      $error("R channel changed while RREADY low");
    end

  lastValid: assert property (@(posedge ACLK) disable iff (!ARESETn) RLAST |-> RVALID)
    else begin
      fails++;
      $error("RLAST without RVALID");
    end

  wNotB: assert property (@(posedge ACLK) disable iff (!ARESETn) !(WREADY && BVALID))
    else begin
      fails++;
      $error("WREADY and BVALID high together");
    end

endmodule

bind axiMemTop axiMemAsserts #(.IdWidth(IdWidth), .DataWidth(DataWidth)) protoChecks (
  .ACLK(ACLK), .ARESETn(ARESETn), .WREADY(WREADY),
  .BID(BID), .BRESP(BRESP), .BVALID(BVALID), .BREADY(BREADY),
  .RDATA(RDATA), .RLAST(RLAST), .RVALID(RVALID), .RREADY(RREADY)
);

//--- dv/axiMemTb.sv
/*
 * Testbench for the AXI memory slave. Drives LFSR-chosen bursts on the
 * plain AXI ports, keeps a word model of the memory and checks B and R.
 */
module axiMemTb;
  timeunit 1ns;
  timeprecision 100ps;
  import axiPkg::*;

  localparam int Timeout = 200;  // cycles per wait
  localparam int Words   = 256;  // 1024 bytes, 4 per word

  logic        ACLK, ARESETn;
  logic [3:0]  AWID, ARID, BID, RID, WSTRB;
  logic [31:0] AWADDR, ARADDR, WDATA, RDATA;
  logic [7:0]  AWLEN, ARLEN;
  logic [2:0]  AWSIZE, ARSIZE;
  logic [1:0]  BRESP, RRESP;
  logic        AWVALID, AWREADY, WLAST, WVALID, WREADY, BVALID, BREADY;
  logic        ARVALID, ARREADY, RLAST, RVALID, RREADY;

  logic [31:0] model [Words];
  logic [15:0] lfsr = 16'd66;
  int          checks, errors, testChecks, testErrors;

  axiMemTop UUT (.*);

  initial begin
    ACLK = 1'b0;
    forever #20 ACLK = ~ACLK;
  end

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11, one step per bit
  function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // strobe merge into the word that holds byte address a
  function automatic void modelWrite(logic [31:0] a, logic [31:0] d, logic [3:0] s);
    int idx;
    idx = (a >> 2) % Words;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) model[idx][8*b +: 8] = d[8*b +: 8];
    end
  endfunction

  task automatic step;
    @(posedge ACLK);
    #2;  // drive point
  endtask

  task automatic giveUp(input string what);
    $display("timeout: no %s within %0d cycles", what, Timeout);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic tick(inout int n, input string what);
    n++;
    if (n > Timeout) giveUp(what);
    step();
  endtask

  task automatic check(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      errors++;
      $display("** Error at %0t: %s", $time, msg);
    end
  endtask

  task automatic endTest(input string name);
    $display("%-24s %0d checks, %0d errors", name, checks - testChecks, errors - testErrors);
    testChecks = checks;
    testErrors = errors;
  endtask

  task automatic pickBurst(output logic [3:0] id, output logic [31:0] addr, output int len,
                           input sizeE size);
    id   = 4'(randBits(4));
    len  = randBits(3);  // 1 to 8 beats
    addr = (size == Size4) ? randBits(8) << 2 : randBits(9) << 1;
  endtask

  //--------------------------------------------------------------------
  // write burst, lastAt is the beat index that carries WLAST
  //--------------------------------------------------------------------
  task automatic writeBurst(input logic [3:0] id, input logic [31:0] addr, input int len,
                            input sizeE size, input int lastAt);
    logic [31:0] a, d;
    logic [3:0]  s;
    logic [1:0]  expResp;
    int          n;
    a       = addr;
    AWID    = id;
    AWADDR  = addr;
    AWLEN   = 8'(len);
    AWSIZE  = size;
    AWVALID = 1'b1;
    n = 0;
    forever begin
      @(negedge ACLK);
      if (AWREADY) break;
      tick(n, "AWREADY");
    end
    step();
    AWVALID = 1'b0;
    for (int i = 0; i <= len; i++) begin
      d = randBits(32);
      if (size == Size4) s = 4'(randBits(4));
      else s = a[1] ? 4'b1100 : 4'b0011;  // half-word lane
      WDATA  = d;
      WSTRB  = s;
      WLAST  = (i == lastAt);
      WVALID = 1'b1;
      n = 0;
      forever begin
        @(negedge ACLK);
        if (WREADY) break;
        tick(n, "WREADY");
      end
      modelWrite(a, d, s);
      a += 32'd1 << size;
      step();
    end
    WVALID  = 1'b0;
    WLAST   = 1'b0;
    expResp = (lastAt == len) ? RespOkay : RespSlvErr;
    n = 0;
    forever begin
      BREADY = (randBits(2) != 2'd0);  // stall about one cycle in four
      @(negedge ACLK);
      if (BVALID && BREADY) break;
      tick(n, "BVALID");
    end
    check(BID == id, $sformatf("BID %h, expected %h", BID, id));
    check(BRESP == expResp, $sformatf("BRESP %0d, expected %0d", BRESP, expResp));
    step();
    BREADY = 1'b0;
  endtask

  task automatic sendAr(input logic [3:0] id, input logic [31:0] addr, input int len,
                        input sizeE size);
    int n;
    ARID    = id;
    ARADDR  = addr;
    ARLEN   = 8'(len);
    ARSIZE  = size;
    ARVALID = 1'b1;
    n = 0;
    forever begin
      @(negedge ACLK);
      if (ARREADY) break;
      tick(n, "ARREADY");
    end
    step();
    ARVALID = 1'b0;
  endtask

  task automatic collectR(input logic [3:0] id, input logic [31:0] addr, input int len,
                          input sizeE size);
    logic [31:0] a, want;
    int          n;
    a = addr;
    for (int i = 0; i <= len; i++) begin
      n = 0;
      forever begin
        RREADY = (randBits(2) != 2'd0);
        @(negedge ACLK);
        if (RVALID && RREADY) break;
        tick(n, "RVALID");
      end
      want = model[(a >> 2) % Words];
      check(RDATA == want, $sformatf("RDATA %h at %h, expected %h", RDATA, a, want));
      check(RID == id && RRESP == RespOkay,
            $sformatf("RID %h RRESP %0d, expected %h and okay", RID, RRESP, id));
      check(RLAST == (i == len), $sformatf("RLAST %b on beat %0d of %0d", RLAST, i + 1, len + 1));
      a += 32'd1 << size;
      step();
    end
    RREADY = 1'b0;
  endtask

  task automatic readBurst(input logic [3:0] id, input logic [31:0] addr, input int len,
                           input sizeE size);
    sendAr(id, addr, len, size);
    collectR(id, addr, len, size);
  endtask

  //--------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------
  initial begin
    logic [3:0]  id [3];
    logic [31:0] addr [3];
    int          len [3];
    $timeformat(-9, 1, " ns", 0);
    {AWID, AWADDR, AWLEN, AWSIZE, AWVALID} = '0;
    {WDATA, WSTRB, WLAST, WVALID, BREADY} = '0;
    {ARID, ARADDR, ARLEN, ARSIZE, ARVALID, RREADY} = '0;
    ARESETn = 1'b0;
    for (int k = 0; k < Words; k++) model[k] = 32'(k);
    repeat (8) @(posedge ACLK);
    #2;
    ARESETn = 1'b1;
    step();

    @(negedge ACLK);
    check(AWREADY && ARREADY, "AWREADY or ARREADY low after reset");
    check(!WREADY && !BVALID && !RVALID, "WREADY, BVALID or RVALID high after reset");
    step();
    endTest("reset state");

    repeat (4) begin
      pickBurst(id[0], addr[0], len[0], Size4);
      readBurst(id[0], addr[0], len[0], Size4);
    end
    endTest("initial contents");

    repeat (4) begin
      pickBurst(id[0], addr[0], len[0], Size4);
      writeBurst(id[0], addr[0], len[0], Size4, len[0]);
      readBurst(id[0], addr[0], len[0], Size4);
    end
    endTest("full-width write/read");

    repeat (4) begin
      pickBurst(id[0], addr[0], len[0], Size2);
      writeBurst(id[0], addr[0], len[0], Size2, len[0]);
      readBurst(id[0], addr[0], len[0], Size2);
    end
    endTest("narrow beats");

    // early WLAST, then no WLAST at all
    pickBurst(id[0], addr[0], len[0], Size4);
    len[0] = 1 + randBits(2);
    writeBurst(id[0], addr[0], len[0], Size4, len[0] - 1);
    readBurst(id[0], addr[0], len[0], Size4);
    pickBurst(id[0], addr[0], len[0], Size4);
    writeBurst(id[0], addr[0], len[0], Size4, -1);
    readBurst(id[0], addr[0], len[0], Size4);
    endTest("wlast error");

    for (int k = 0; k < 3; k++) pickBurst(id[k], addr[k], len[k], Size4);
    for (int k = 0; k < 3; k++) sendAr(id[k], addr[k], len[k], Size4);
    for (int k = 0; k < 3; k++) collectR(id[k], addr[k], len[k], Size4);
    @(negedge ACLK);
    check(!RVALID, "RVALID still high after the last queued burst");
    step();
    endTest("queueing");

    errors += UUT.protoChecks.fails;  // protocol assertion failures
    $display("total %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- src.f
rtl/axiPkg.sv
rtl/engPkg.sv
rtl/addrCmdIf.sv
rtl/memWrIf.sv
rtl/axiAddrQueue.sv
rtl/axiWriteEngine.sv
rtl/axiReadEngine.sv
rtl/axiMemArray.sv
rtl/axiMemTop.sv
dv/axiMem_asserts.sv
dv/axiMemTb.sv

//--- Bender.yml
package:
  name: axi_mem_slave

sources:
  - rtl/axiPkg.sv
  - rtl/engPkg.sv
  - rtl/addrCmdIf.sv
  - rtl/memWrIf.sv
  - rtl/axiAddrQueue.sv
  - rtl/axiWriteEngine.sv
  - rtl/axiReadEngine.sv
  - rtl/axiMemArray.sv
  - rtl/axiMemTop.sv
  - target: test
    files:
      - dv/axiMem_asserts.sv
      - dv/axiMemTb.sv
